// File: common/fp96Pkg.sv
// shared definitions for the 96-bit float compare peripheral
//   float format constants and field typedefs
//   FP96 float struct, decomposed parts and class flags
//   compare result struct
//   APB data type and register map offsets

package fp96Pkg;

	// ====================
	// float format
	// ====================
	localparam int EMSB = 14;	// top exponent bit
	localparam int FMSB = 79;	// top significand bit

	typedef logic [EMSB:0]   fpExp;		// biased exponent
	typedef logic [FMSB:0]   fpSig;		// stored significand
	typedef logic [FMSB+1:0] fpFract;	// significand with hidden bit

	// 1 + 15 + 80 = 96 bits
	typedef struct packed {
		logic sign;
		fpExp exp;
		fpSig sig;
	} FP96;

	// decomposed operand, 97 bits
	typedef struct packed {
		logic   sgn;
		fpExp   exp;
		fpFract fract;	// hidden bit restored
	} fpParts;

	// class flags, read back in bits 8..0
	typedef struct packed {
		logic sgn;	// sign
		logic xz;	// exponent all zero
		logic mz;	// mantissa all zero
		logic vz;	// value zero
		logic inf;	// infinity
		logic xinf;	// exponent all ones
		logic qnan;	// quiet nan
		logic snan;	// signalling nan
		logic nan;	// any nan
	} fpClass;

	// compare result, read back in bits 3..0
	typedef struct packed {
		logic lt;
		logic eq;
		logic gt;
		logic unord;
	} fpCmp;

	// ====================
	// APB register map
	// ====================
	typedef logic [31:0] apbData;
	typedef logic [7:0]  regOff;	// byte offset of a register

	localparam regOff AddrA0   = 8'h00;	// operand A bits 31..0
	localparam regOff AddrA1   = 8'h04;
	localparam regOff AddrA2   = 8'h08;	// operand A bits 95..64
	localparam regOff AddrB0   = 8'h0C;
	localparam regOff AddrB1   = 8'h10;
	localparam regOff AddrB2   = 8'h14;
	localparam regOff AddrCtrl = 8'h18;	// bit 0 start
	localparam regOff AddrStat = 8'h1C;	// bit 0 done, bit 1 busy
	localparam regOff AddrClsA = 8'h20;
	localparam regOff AddrClsB = 8'h24;
	localparam regOff AddrCmp  = 8'h28;

endpackage

// File: fpu/fpDecomp96Reg.sv
// registered decomposer for one 96-bit float operand
//   splits sign, exponent and significand
//   restores the hidden bit
//   flags zero, infinity and nan classes
//   all outputs load under clock enable

`timescale 1ns/1ps

module fpDecomp96Reg
	import fp96Pkg::*;
(
	input  logic   clk,
	input  logic   ce,	// load enable, one pulse per operation
	input  FP96    i,
	output FP96    o,	// operand passed through
	output fpParts parts,
	output fpClass cls
);

	fpParts partsD;
	fpClass clsD;
	logic   expOnes;
	logic   expZero;
	logic   manZero;

	// ====================
	// field decode
	// ====================
	assign expOnes = &i.exp;
	assign expZero = ~|i.exp;	// denormal or zero
	assign manZero = ~|i.sig;

	always_comb begin
		partsD.sgn   = i.sign;
		partsD.exp   = i.exp;
		partsD.fract = {~expZero, i.sig};	// hidden bit set for normals only

		clsD.sgn  = i.sign;
		clsD.xz   = expZero;
		clsD.mz   = manZero;
		clsD.vz   = expZero & manZero;	// +0 or -0
		clsD.inf  = expOnes & manZero;
		clsD.xinf = expOnes;
		// top significand bit picks quiet vs signalling
		clsD.qnan = expOnes & i.sig[FMSB];
		clsD.snan = expOnes & ~i.sig[FMSB] & ~manZero;
		clsD.nan  = expOnes & ~manZero;
	end

	// ====================
	// output registers
	// ====================
	// held while ce is low so the class readback stays stable
	always_ff @(posedge clk) begin
		if (ce) begin
			o     <= i;
			parts <= partsD;
			cls   <= clsD;
		end
	end

	// a loaded value never shows both nan kinds
	assert property (@(posedge clk) ce |=> !(cls.qnan && cls.snan))
		else $error("decomposer flagged quiet and signalling nan together");

	// infinity and nan are exclusive on the registered flags
	assert property (@(posedge clk) ce |=> (!cls.inf || !cls.nan))
		else $error("decomposer flagged infinity as nan");

endmodule

// File: fpu/fpCompare96.sv
// registered comparator for two decomposed 96-bit floats
//   go is delayed one cycle to meet the decomposer outputs
//   unordered on any nan
//   +0 and -0 compare equal
//   sign then magnitude ordering, reversed for two negatives
//   one-cycle done pulse with the result

`timescale 1ns/1ps

module fpCompare96
	import fp96Pkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   go,	// same pulse that loads the decomposers
	input  fpParts pa,
	input  fpParts pb,
	input  fpClass ca,
	input  fpClass cb,
	output fpCmp   cmp,
	output logic   done	// result valid pulse
);

	logic goD;		// decomposer outputs valid in this cycle
	logic unord;
	logic bothZero;
	logic same;
	logic magLt;	// |a| < |b|
	logic magGt;	// |a| > |b|
	fpCmp cmpD;

	// ====================
	// compare logic
	// ====================
	assign unord    = ca.nan | cb.nan;
	assign bothZero = ca.vz & cb.vz;	// sign ignored
	assign same     = (pa == pb);

	// exponent over fraction gives the magnitude order directly
	assign magLt = {pa.exp, pa.fract} < {pb.exp, pb.fract};
	assign magGt = {pa.exp, pa.fract} > {pb.exp, pb.fract};

	always_comb begin
		cmpD = '0;
		if (unord) begin
			cmpD.unord = 1'b1;
		end else if (bothZero || same) begin
			cmpD.eq = 1'b1;
		end else if (pa.sgn != pb.sgn) begin
			// differing signs, negative side is smaller
			cmpD.lt = pa.sgn;
			cmpD.gt = pb.sgn;
		end else if (pa.sgn) begin
			cmpD.lt = magGt;	// both negative, order flips
			cmpD.gt = magLt;
		end else begin
			cmpD.lt = magLt;
			cmpD.gt = magGt;
		end
	end

	// ====================
	// pipeline registers
	// ====================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			goD  <= 1'b0;
			cmp  <= '0;
			done <= 1'b0;
		end else begin
			goD  <= go;
			done <= goD;
			if (goD) begin
				cmp <= cmpD;	// held until the next operation
			end
		end
	end

	// each completed compare reports exactly one outcome
	assert property (@(posedge clk) disable iff (!rstN)
		$rose(done) |-> $onehot({cmp.lt, cmp.eq, cmp.gt, cmp.unord}))
		else $error("compare result not one-hot at done");

endmodule

// File: design/fpCmpRegs.sv
// APB slave register file for the float compare peripheral
//   six operand words, write-only start control
//   busy and done status tracking
//   readback mux, class and cmp masked until first done
//   pslverr on unmapped address or read-only write
//   zero wait states

`timescale 1ns/1ps

module fpCmpRegs
	import fp96Pkg::*;
#(
	parameter int AddrW = 8
) (
	input  logic             clk,
	input  logic             rstN,
	// APB slave
	input  logic [AddrW-1:0] paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  apbData           pwdata,
	output apbData           prdata,
	output logic             pready,
	output logic             pslverr,
	// pipeline side
	output FP96              opA,
	output FP96              opB,
	output logic             start,	// one-cycle load pulse
	input  logic             done,
	input  fpCmp             cmp,
	input  fpClass           clsA,
	input  fpClass           clsB
);

	logic   access;		// APB access phase completes this edge
	logic   wrEn;
	logic   busyReg;
	logic   doneReg;
	logic   busyEff;	// busy with this cycle's done folded in
	logic   doneEff;
	logic   resValid;	// a result has completed since reset
	logic   startReq;
	logic   mapped;
	logic   roReg;		// register rejects writes
	apbData rdData;

	assign access = psel & penable;
	assign wrEn   = access & pwrite;
	assign pready = 1'b1;

	// done lands one edge before the status flops pick it up
	assign busyEff = busyReg & ~done;
	assign doneEff = doneReg | done;

	assign startReq = wrEn && (paddr == AddrW'(AddrCtrl)) && pwdata[0];

	// ====================
	// address decode
	// ====================
	always_comb begin
		rdData = '0;
		mapped = 1'b1;
		roReg  = 1'b0;
		case (paddr)
			AddrW'(AddrA0):   rdData = opA[31:0];
			AddrW'(AddrA1):   rdData = opA[63:32];
			AddrW'(AddrA2):   rdData = opA[95:64];
			AddrW'(AddrB0):   rdData = opB[31:0];
			AddrW'(AddrB1):   rdData = opB[63:32];
			AddrW'(AddrB2):   rdData = opB[95:64];
			AddrW'(AddrCtrl): rdData = '0;	// start bit self-clears
			AddrW'(AddrStat): begin
				rdData = {30'b0, busyEff, doneEff};
				roReg  = 1'b1;
			end
			AddrW'(AddrClsA): begin
				rdData = resValid ? apbData'(clsA) : '0;
				roReg  = 1'b1;
			end
			AddrW'(AddrClsB): begin
				rdData = resValid ? apbData'(clsB) : '0;
				roReg  = 1'b1;
			end
			AddrW'(AddrCmp): begin
				rdData = resValid ? apbData'(cmp) : '0;
				roReg  = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	// response only shows in the access phase
	assign prdata  = (access && !pwrite) ? rdData : '0;
	assign pslverr = access & (~mapped | (pwrite & roReg));

	// ====================
	// operand registers
	// ====================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			opA <= '0;
			opB <= '0;
		end else if (wrEn) begin
			case (paddr)
				AddrW'(AddrA0): opA[31:0]  <= pwdata;
				AddrW'(AddrA1): opA[63:32] <= pwdata;
				AddrW'(AddrA2): opA[95:64] <= pwdata;
				AddrW'(AddrB0): opB[31:0]  <= pwdata;
				AddrW'(AddrB1): opB[63:32] <= pwdata;
				AddrW'(AddrB2): opB[95:64] <= pwdata;
				default: ;	// other registers not stored here
			endcase
		end
	end

	// ====================
	// start and status
	// ====================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			start    <= 1'b0;
			busyReg  <= 1'b0;
			doneReg  <= 1'b0;
			resValid <= 1'b0;
		end else begin
			start <= startReq & ~busyEff;	// start while busy is dropped
			if (startReq && !busyEff) begin
				busyReg <= 1'b1;
				doneReg <= 1'b0;
			end else if (done) begin
				busyReg <= 1'b0;
				doneReg <= 1'b1;
			end
			if (done) begin
				resValid <= 1'b1;	// sticky
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) pslverr |-> (psel && penable))
		else $error("pslverr outside the access phase");

	// fixed two-cycle pipeline after the load pulse
	assert property (@(posedge clk) disable iff (!rstN) start |-> ##2 done)
		else $error("pipeline did not complete two cycles after start");

endmodule

// File: design/fpCmpApb.sv
// top level of the APB float compare peripheral
//   register file, two registered decomposers, comparator
//   stage one decomposes both operands on the start pulse
//   stage two registers the compare result and done

`timescale 1ns/1ps

module fpCmpApb
	import fp96Pkg::*;
#(
	parameter int AddrW = 8
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic [AddrW-1:0] paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  apbData           pwdata,
	output apbData           prdata,
	output logic             pready,
	output logic             pslverr
);

	FP96    opA;
	FP96    opB;
	logic   start;
	logic   done;
	fpParts partsA;
	fpParts partsB;
	fpClass clsA;
	fpClass clsB;
	fpCmp   cmp;

	fpCmpRegs #(
		.AddrW(AddrW)
	) regs (
		.clk    (clk),
		.rstN   (rstN),
		.paddr  (paddr),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr),
		.opA    (opA),
		.opB    (opB),
		.start  (start),
		.done   (done),
		.cmp    (cmp),
		.clsA   (clsA),
		.clsB   (clsB)
	);

	// ====================
	// stage one
	// ====================
	fpDecomp96Reg decA (
		.clk  (clk),
		.ce   (start),
		.i    (opA),
		.o    (),	// pass-through unused here
		.parts(partsA),
		.cls  (clsA)
	);

	fpDecomp96Reg decB (
		.clk  (clk),
		.ce   (start),
		.i    (opB),
		.o    (),
		.parts(partsB),
		.cls  (clsB)
	);

	// stage two
	fpCompare96 cmpU (
		.clk (clk),
		.rstN(rstN),
		.go  (start),
		.pa  (partsA),
		.pb  (partsB),
		.ca  (clsA),
		.cb  (clsB),
		.cmp (cmp),
		.done(done)
	);

endmodule

// File: bench/fpCmpChecker.sv
// checker for the APB float compare peripheral
//   mirrors operand writes and the start pipeline in a model
//   classifies and orders floats from the format rules
//   checks pready and pslverr on every transfer and prdata on every read

`timescale 1ns/1ps

module fpCmpChecker
	import fp96Pkg::*;
#(
	parameter int AddrW = 8
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic [AddrW-1:0] paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  apbData           pwdata,
	input  apbData           prdata,
	input  logic             pready,
	input  logic             pslverr,
	output int               errors
);

	logic [95:0] opA;	// model operand registers
	logic [95:0] opB;
	logic [95:0] snapA;	// operands taken by the accepted start
	logic [95:0] snapB;
	apbData      clsAM;
	apbData      clsBM;
	apbData      cmpM;
	int          stage;		// 1 and 2 busy, 3 done pulse, 0 idle
	logic        doneM;
	logic        validM;	// a result has landed since reset
	logic        accept;
	logic        mapped;
	int          idx;
	string       name;
	apbData      expData;
	logic        expErr;
	string       regNames [0:10] = '{"A0", "A1", "A2", "B0", "B1", "B2",
		"CTRL", "STATUS", "CLS_A", "CLS_B", "CMP"};

	// flag word of sgn xz mz vz inf xinf qnan snan nan
	function automatic apbData classify(input logic [95:0] f);
		logic xz;
		logic mz;
		logic ones;
		xz   = (f[94:80] == 15'h0);
		mz   = (f[79:0] == 80'h0);
		ones = (f[94:80] == 15'h7FFF);
		return {23'b0, f[95], xz, mz, xz & mz, ones & mz, ones,
			ones & f[79], ones & !f[79] & !mz, ones & !mz};
	endfunction

	// result word of lt eq gt unord
	function automatic apbData compare(input logic [95:0] a, input logic [95:0] b);
		logic aNan;
		logic bNan;
		aNan = (a[94:80] == 15'h7FFF) && (a[79:0] != 80'h0);
		bNan = (b[94:80] == 15'h7FFF) && (b[79:0] != 80'h0);
		if (aNan || bNan) return 32'h1;
		if (a[94:0] == 95'h0 && b[94:0] == 95'h0) return 32'h4;	// +0 == -0
		if (a == b) return 32'h4;
		if (a[95] != b[95]) return a[95] ? 32'h8 : 32'h2;
		// magnitude order flips when both are negative
		if ((a[94:0] < b[94:0]) != a[95]) return 32'h8;
		return 32'h2;
	endfunction

	initial errors = 0;

	// ====================
	// access phase is stable at mid-cycle
	// ====================
	always @(negedge clk) begin
		accept = 1'b0;
		if (!rstN) begin
			opA    = '0;
			opB    = '0;
			clsAM  = '0;
			clsBM  = '0;
			cmpM   = '0;
			stage  = 0;
			doneM  = 1'b0;
			validM = 1'b0;
		end else begin
			if (psel && penable) begin	// completes on the next rising edge
				mapped = (paddr[1:0] == 2'b00) && (paddr <= AddrW'(AddrCmp));
				idx    = int'(paddr) / 4;
				if (mapped) name = regNames[idx];
				else name = "unmapped";
				expErr = !mapped || (pwrite && idx >= 7);	// STATUS and results read-only
				case (paddr)
					AddrW'(AddrA0):   expData = opA[31:0];
					AddrW'(AddrA1):   expData = opA[63:32];
					AddrW'(AddrA2):   expData = opA[95:64];
					AddrW'(AddrB0):   expData = opB[31:0];
					AddrW'(AddrB1):   expData = opB[63:32];
					AddrW'(AddrB2):   expData = opB[95:64];
					AddrW'(AddrStat): expData = {30'b0, stage == 1 || stage == 2, doneM};
					AddrW'(AddrClsA): expData = validM ? clsAM : '0;
					AddrW'(AddrClsB): expData = validM ? clsBM : '0;
					AddrW'(AddrCmp):  expData = validM ? cmpM : '0;
					default:          expData = '0;	// CTRL and holes read zero
				endcase
				if (pready !== 1'b1) begin	// no wait states
					errors++;
					$display("FAIL %s pready expected %h actual %h", name, 1'b1, pready);
				end
				if (pslverr !== expErr) begin
					errors++;
					$display("FAIL %s pslverr expected %h actual %h", name, expErr, pslverr);
				end
				if (!pwrite && prdata !== expData) begin
					errors++;
					$display("FAIL %s prdata expected %h actual %h", name, expData, prdata);
				end
				if (pwrite) begin
					case (paddr)
						AddrW'(AddrA0): opA[31:0]  = pwdata;
						AddrW'(AddrA1): opA[63:32] = pwdata;
						AddrW'(AddrA2): opA[95:64] = pwdata;
						AddrW'(AddrB0): opB[31:0]  = pwdata;
						AddrW'(AddrB1): opB[63:32] = pwdata;
						AddrW'(AddrB2): opB[95:64] = pwdata;
						default: ;
					endcase
				end
				accept = pwrite && paddr == AddrW'(AddrCtrl) && pwdata[0]
					&& stage != 1 && stage != 2;	// start while busy dropped
			end
			// pipeline state after the coming edge
			case (stage)
				1: begin
					clsAM = classify(snapA);
					clsBM = classify(snapB);
					stage = 2;
				end
				2: begin
					cmpM  = compare(snapA, snapB);
					doneM = 1'b1;
					stage = 3;
				end
				3: begin
					validM = 1'b1;
					stage  = 0;
				end
				default: ;
			endcase
			if (accept) begin
				snapA = opA;
				snapB = opB;
				stage = 1;
				doneM = 1'b0;
			end
		end
	end

endmodule

// File: bench/fpCmpApbTb.sv
// testbench top for the APB float compare peripheral
//   clock, reset and APB master tasks
//   directed, random and busy-path tests
//   cycle-count timeout and closing summary

`timescale 1ns/1ps

module fpCmpApbTb
	import fp96Pkg::*;
();

	localparam int AddrW      = 8;
	localparam int RandPairs  = 200;
	localparam int XferPerCmp = 13;	// six operand writes, start, polls, three reads
	localparam int XferTotal  = 4 + 3 * XferPerCmp + RandPairs * XferPerCmp
		+ 6 * XferPerCmp + 24 + 13;
	localparam int CycleLimit = XferTotal * 4 + 200;

	localparam logic [95:0] NegZero = 96'h8000_0000_0000_0000_0000_0000;
	localparam logic [95:0] PosInf  = 96'h7FFF_0000_0000_0000_0000_0000;
	localparam logic [95:0] QNan    = 96'h7FFF_8000_0000_0000_0000_0000;
	localparam logic [95:0] SNan    = 96'h7FFF_0000_0000_0000_0000_0001;
	localparam logic [95:0] PosOne  = 96'h3FFF_8000_0000_0000_0000_0000;
	localparam logic [95:0] NegOne  = 96'hBFFF_8000_0000_0000_0000_0000;
	localparam logic [95:0] PosTwo  = 96'h4000_8000_0000_0000_0000_0000;
	localparam logic [95:0] NegTwo  = 96'hC000_8000_0000_0000_0000_0000;

	logic             clk;
	logic             rstN;
	logic [AddrW-1:0] paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	apbData           pwdata;
	apbData           prdata;
	logic             pready;
	logic             pslverr;
	int               checkErrors;
	int               tbErrors = 0;
	int               passCount = 0;
	int               failCount = 0;
	int               cycles;

	fpCmpApb #(.AddrW(AddrW)) UUT (
		.clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	fpCmpChecker #(.AddrW(AddrW)) chk (
		.clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .errors(checkErrors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// APB master driven 5 ns after a rising edge
	// ====================
	task automatic apbWrite(input logic [AddrW-1:0] a, input apbData d);
		paddr   = a;
		pwrite  = 1'b1;
		pwdata  = d;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#5 penable = 1'b1;
		@(posedge clk);	// transfer completes here
		#5 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input logic [AddrW-1:0] a, output apbData d);
		paddr   = a;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#5 penable = 1'b1;
		@(negedge clk);
		d = prdata;	// stable mid access phase
		@(posedge clk);
		#5 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic loadOperands(input logic [95:0] a, input logic [95:0] b);
		apbWrite(AddrA0, a[31:0]);
		apbWrite(AddrA1, a[63:32]);
		apbWrite(AddrA2, a[95:64]);
		apbWrite(AddrB0, b[31:0]);
		apbWrite(AddrB1, b[63:32]);
		apbWrite(AddrB2, b[95:64]);
	endtask

	// poll STATUS until done and not busy
	task automatic waitDone();
		apbData s;
		s = '0;
		while (!(s[0] && !s[1])) begin
			apbRead(AddrStat, s);
		end
	endtask

	task automatic runCompare(input logic [95:0] a, input logic [95:0] b,
		output apbData ca, output apbData cb, output apbData c);
		loadOperands(a, b);
		apbWrite(AddrCtrl, 32'h1);
		waitDone();
		apbRead(AddrClsA, ca);
		apbRead(AddrClsB, cb);
		apbRead(AddrCmp, c);
	endtask

	task automatic expectWord(input string what, input apbData exp, input apbData got);
		if (got !== exp) begin
			tbErrors++;
			$display("FAIL %s expected %h actual %h", what, exp, got);
		end
	endtask

	function automatic int totalErrors();
		return tbErrors + checkErrors;
	endfunction

	task automatic endTest(input string name, input int mark);
		if (totalErrors() == mark) begin
			passCount++;
			$display("test %s: passed", name);
		end else begin
			failCount++;
			$display("test %s: failed, %0d errors", name, totalErrors() - mark);
		end
	endtask

	// exponent leans toward all zero and all ones
	function automatic logic [95:0] randFloat();
		logic [95:0] f;
		f = {$urandom, $urandom, $urandom};
		case ($urandom % 4)
			0: f[94:80] = '0;	// zero or denormal
			1: f[94:80] = '1;	// infinity or nan
			default: ;
		endcase
		if ($urandom % 4 == 0) begin
			f[79:0] = '0;
		end
		return f;
	endfunction

	initial begin
		cycles = 0;
		while (cycles < CycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no end of tests after %0d cycles, run stopped", CycleLimit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [95:0] a;
		logic [95:0] b;
		apbData      ca;
		apbData      cb;
		apbData      c;
		int          mark;
		rstN    = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		void'($urandom(87));
		repeat (8) @(posedge clk);
		#5 rstN = 1'b1;

		// ==================== reset state
		mark = totalErrors();
		apbRead(AddrStat, c);
		expectWord("STATUS", 32'h0, c);
		apbRead(AddrClsA, c);
		expectWord("CLS_A", 32'h0, c);
		apbRead(AddrClsB, c);
		expectWord("CLS_B", 32'h0, c);
		apbRead(AddrCmp, c);
		expectWord("CMP", 32'h0, c);
		endTest("reset state", mark);

		// ==================== special values
		mark = totalErrors();
		runCompare(96'h0, NegZero, ca, cb, c);
		expectWord("CLS_A +0", 32'h0E0, ca);
		expectWord("CLS_B -0", 32'h1E0, cb);
		runCompare(96'h1, PosInf, ca, cb, c);
		expectWord("CLS_A denormal", 32'h080, ca);
		expectWord("CLS_B inf", 32'h058, cb);
		expectWord("CMP denormal inf", 32'h8, c);
		runCompare(QNan, SNan, ca, cb, c);
		expectWord("CLS_A qnan", 32'h00D, ca);
		expectWord("CLS_B snan", 32'h00B, cb);
		expectWord("CMP qnan snan", 32'h1, c);
		endTest("special values", mark);

		// ==================== random pairs
		mark = totalErrors();
		for (int n = 0; n < RandPairs; n++) begin
			a = randFloat();
			b = randFloat();
			if ($urandom % 8 == 0) begin
				b = a;
			end else if ($urandom % 4 == 0) begin
				b[94:80] = a[94:80];	// order set by the fraction
			end
			runCompare(a, b, ca, cb, c);
		end
		endTest("random pairs", mark);

		// ==================== ordering
		mark = totalErrors();
		runCompare(PosOne, PosOne, ca, cb, c);
		expectWord("CMP 1 1", 32'h4, c);
		runCompare(NegZero, 96'h0, ca, cb, c);
		expectWord("CMP -0 +0", 32'h4, c);
		runCompare(NegOne, PosOne, ca, cb, c);
		expectWord("CMP -1 1", 32'h8, c);
		runCompare(PosOne, NegOne, ca, cb, c);
		expectWord("CMP 1 -1", 32'h2, c);
		runCompare(NegOne, NegTwo, ca, cb, c);
		expectWord("CMP -1 -2", 32'h2, c);
		runCompare(NegTwo, NegOne, ca, cb, c);
		expectWord("CMP -2 -1", 32'h8, c);
		endTest("ordering", mark);

		// ==================== busy
		mark = totalErrors();
		loadOperands(PosOne, PosTwo);
		apbWrite(AddrCtrl, 32'h1);
		apbWrite(AddrCtrl, 32'h1);	// lands while busy
		waitDone();
		apbRead(AddrCmp, c);
		expectWord("CMP after second start", 32'h8, c);
		apbWrite(AddrCtrl, 32'h1);
		apbWrite(AddrA2, 32'h4000_C000);	// A becomes 3.0 mid flight
		waitDone();
		apbRead(AddrCmp, c);
		expectWord("CMP in flight", 32'h8, c);
		apbWrite(AddrCtrl, 32'h1);
		waitDone();
		apbRead(AddrCmp, c);
		expectWord("CMP next result", 32'h2, c);
		endTest("busy", mark);

		// ==================== error responses
		mark = totalErrors();
		apbRead(8'h2C, c);
		apbWrite(AddrStat, 32'h3);
		for (int r = 0; r <= 40; r += 4) begin
			apbRead(AddrW'(r), c);	// everything must be unchanged
		end
		endTest("error responses", mark);

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: fpCmpApb.f
common/fp96Pkg.sv
fpu/fpDecomp96Reg.sv
fpu/fpCompare96.sv
design/fpCmpRegs.sv
design/fpCmpApb.sv
bench/fpCmpChecker.sv
bench/fpCmpApbTb.sv

// File: Makefile
# Verilator flow for the APB float compare peripheral
#   make        build and run the testbench
#   make lint   lint the RTL top level
#   make clean  remove build output

VERILATOR ?= verilator
TB_TOP    ?= fpCmpApbTb
RTL_TOP   ?= fpCmpApb
FILELIST  ?= fpCmpApb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
